// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hw/rv_pkg.sv
  - hw/rv_decoder.sv
  - hw/rv_regfile.sv
  - hw/rv_alu.sv
  - hw/rv_pc_counter.sv
  - hw/rv_run_ctrl.sv
  - hw/rv_core.sv
  - target: simulation
    files:
      - bench/tb_rv_core.sv

// ==== bench/rv_core_cases.hex ====
// insn     we rd data     next_pc, one case per word address
// skipped words expect no write, so running one is caught at once
00000093 1 01 00000000 00000004 // addi x1, x0, 0
ffb00093 1 01 fffffffb 00000008 // addi x1, x0, -5
00300113 1 02 00000003 0000000c // addi x2, x0, 3
0030a193 1 03 00000001 00000010 // slti x3, x1, 3
0030b213 1 04 00000000 00000014 // sltiu x4, x1, 3
0f00c293 1 05 ffffff0b 00000018 // xori x5, x1, 0xf0
70016313 1 06 00000703 0000001c // ori x6, x2, 0x700
07f0f393 1 07 0000007b 00000020 // andi x7, x1, 0x7f
01e11413 1 08 c0000000 00000024 // slli x8, x2, 30
0040d493 1 09 0fffffff 00000028 // srli x9, x1, 4
40445513 1 0a fc000000 0000002c // srai x10, x8, 4
800005b7 1 0b 80000000 00000030 // lui x11, 0x80000
00208633 1 0c fffffffe 00000034 // add x12, x1, x2
402586b3 1 0d 7ffffffd 00000038 // sub x13, x11, x2
00211733 1 0e 00000018 0000003c // sll x14, x2, x2
0020a7b3 1 0f 00000001 00000040 // slt x15, x1, x2
0020b833 1 10 00000000 00000044 // sltu x16, x1, x2
00b0c8b3 1 11 7ffffffb 00000048 // xor x17, x1, x11
0025d933 1 12 10000000 0000004c // srl x18, x11, x2
4025d9b3 1 13 f0000000 00000050 // sra x19, x11, x2
00816a33 1 14 c0000003 00000054 // or x20, x2, x8
00c3fab3 1 15 0000007a 00000058 // and x21, x7, x12
12300013 1 00 00000123 0000005c // addi x0, x0, 0x123
00000b33 1 16 00000000 00000060 // add x22, x0, x0
00208463 0 00 00000000 00000064 // beq x1, x2, +8 not taken
00210463 0 00 00000000 0000006c // beq x2, x2, +8 taken
fff00f93 0 00 00000000 00000000 // skipped
00211463 0 00 00000000 00000070 // bne x2, x2, +8 not taken
00209463 0 00 00000000 00000078 // bne x1, x2, +8 taken
fff00f93 0 00 00000000 00000000 // skipped
00114463 0 00 00000000 0000007c // blt x2, x1, +8 not taken
0020c463 0 00 00000000 00000084 // blt x1, x2, +8 taken
fff00f93 0 00 00000000 00000000 // skipped
0020d463 0 00 00000000 00000088 // bge x1, x2, +8 not taken
00115463 0 00 00000000 00000090 // bge x2, x1, +8 taken
fff00f93 0 00 00000000 00000000 // skipped
0020e463 0 00 00000000 00000094 // bltu x1, x2, +8 not taken
00116463 0 00 00000000 0000009c // bltu x2, x1, +8 taken
fff00f93 0 00 00000000 00000000 // skipped
00117463 0 00 00000000 000000a0 // bgeu x2, x1, +8 not taken
0020f463 0 00 00000000 000000a8 // bgeu x1, x2, +8 taken
fff00f93 0 00 00000000 00000000 // skipped
00800bef 1 17 000000ac 000000b0 // jal x23, +8
fff00f93 0 00 00000000 00000000 // skipped
00db8c67 1 18 000000b4 000000b8 // jalr x24, 13(x23), bit 0 dropped
fff00f93 0 00 00000000 00000000 // skipped
00000073 0 00 00000000 000000b8 // ecall

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_CASES    = 47;
  localparam int CASE_FIELDS  = 5;
  localparam int HALT_CYCLES  = 5;
  // each case runs at most once with margin for the halt cycles
  localparam int CYCLE_LIMIT  = NUM_CASES + 40;

  logic        clk;
  logic        rst;
  logic [31:0] i_insn;
  logic [31:0] o_pc;
  logic        o_halt;
  logic        o_commit_we;
  logic [4:0]  o_commit_rd;
  logic [31:0] o_commit_data;

  // five words per case for insn, write flag, rd, write data and next pc
  logic [31:0] case_mem [NUM_CASES*CASE_FIELDS];
  int          cycle_count = 0;

  rv_core uut (
    .clk           (clk),
    .rst           (rst),
    .i_insn        (i_insn),
    .o_pc          (o_pc),
    .o_halt        (o_halt),
    .o_commit_we   (o_commit_we),
    .o_commit_rd   (o_commit_rd),
    .o_commit_data (o_commit_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  // post-reset cycle budget
  always @(posedge clk) begin
    if (!rst) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
        stop_on_error("core never halted within the cycle limit");
      end
    end
  end

  // serve the word at o_pc and check its commit and the next pc
  task automatic run_case();
    int          idx;
    int          base;
    logic [31:0] exp_we;
    logic [31:0] exp_rd;
    logic [31:0] exp_data;
    logic [31:0] exp_next;
    logic [31:0] exp_halt;
    idx = int'(o_pc >> 2);
    assert (idx < NUM_CASES)
      else stop_on_error($sformatf("pc 0x%h lies outside the program", o_pc));
    base     = idx * CASE_FIELDS;
    exp_we   = case_mem[base + 1];
    exp_rd   = case_mem[base + 2];
    exp_data = case_mem[base + 3];
    exp_next = case_mem[base + 4];
    // the last case is the ecall
    exp_halt = {31'd0, idx == NUM_CASES - 1};
    i_insn   = case_mem[base];
    #(CLK_PERIOD/2 - 1);
    assert ({31'd0, o_commit_we} == exp_we)
      else report_mismatch("o_commit_we", {31'd0, o_commit_we}, exp_we);
    if (exp_we[0]) begin
      assert ({27'd0, o_commit_rd} == exp_rd)
        else report_mismatch("o_commit_rd", {27'd0, o_commit_rd}, exp_rd);
      assert (o_commit_data == exp_data)
        else report_mismatch("o_commit_data", o_commit_data, exp_data);
    end
    @(posedge clk);
    #1;
    assert (o_pc == exp_next) else report_mismatch("o_pc", o_pc, exp_next);
    assert ({31'd0, o_halt} == exp_halt)
      else report_mismatch("o_halt", {31'd0, o_halt}, exp_halt);
    @(negedge clk);
  endtask

  initial begin : main_seq
    logic [31:0] halt_pc;
    rst    = 1'b1;
    i_insn = 32'd0;
    $readmemh("bench/rv_core_cases.hex", case_mem);
    repeat (RESET_CYCLES) @(negedge clk);
    // opcode 0 is illegal so nothing commits while it is held
    assert (o_pc == 32'd0) else report_mismatch("o_pc", o_pc, 32'd0);
    assert (o_halt == 1'b0) else report_mismatch("o_halt", {31'd0, o_halt}, 32'd0);
    assert (o_commit_we == 1'b0)
      else report_mismatch("o_commit_we", {31'd0, o_commit_we}, 32'd0);
    rst = 1'b0;
    while (!o_halt) begin
      run_case();
    end
    // the ecall's next pc is its own address
    halt_pc = case_mem[(NUM_CASES - 1) * CASE_FIELDS + 4];
    repeat (HALT_CYCLES) begin
      i_insn = case_mem[(halt_pc >> 2) * CASE_FIELDS];
      #(CLK_PERIOD/2 - 1);
      assert (o_commit_we == 1'b0)
        else report_mismatch("o_commit_we", {31'd0, o_commit_we}, 32'd0);
      @(posedge clk);
      #1;
      assert (o_pc == halt_pc) else report_mismatch("o_pc", o_pc, halt_pc);
      assert (o_halt == 1'b1) else report_mismatch("o_halt", {31'd0, o_halt}, 32'd1);
      @(negedge clk);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
  input  alu_op_e i_op,
  input  word_t   i_a,
  input  word_t   i_b,
  input  word_t   i_pc,
  output word_t   o_result,
  output logic    o_take
);

  shamt_t shamt;
  logic   eq;
  logic   lt_s;
  logic   lt_u;

  assign shamt = i_b[4:0];

  // compare flags shared by slt and the branches
  assign eq   = (i_a == i_b);
  assign lt_s = ($signed(i_a) < $signed(i_b));
  assign lt_u = (i_a < i_b);

  always_comb begin
    o_result = '0;
    o_take   = 1'b0;
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_SLL:    o_result = i_a << shamt;
      ALU_SLT:    o_result = {31'd0, lt_s};
      ALU_SLTU:   o_result = {31'd0, lt_u};
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SRL:    o_result = i_a >> shamt;
      // sign fill from bit 31
      ALU_SRA:    o_result = word_t'($signed(i_a) >>> shamt);
      ALU_OR:     o_result = i_a | i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_PASS_B: o_result = i_b;
      ALU_LINK:   o_result = i_pc + INSN_BYTES;
      ALU_EQ:     o_take = eq;
      ALU_NE:     o_take = !eq;
      ALU_LT:     o_take = lt_s;
      ALU_GE:     o_take = !lt_s;
      ALU_LTU:    o_take = lt_u;
      ALU_GEU:    o_take = !lt_u;
      default: begin
        o_result = '0;
        o_take   = 1'b0;
      end
    endcase
  end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic      clk,
  input  logic      rst,
  input  word_t     i_insn,
  output word_t     o_pc,
  output logic      o_halt,
  output logic      o_commit_we,
  output reg_addr_t o_commit_rd,
  output word_t     o_commit_data
);

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  alu_op_e   alu_op;
  logic      use_imm;
  logic      reg_we;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  logic      stop;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_b;
  word_t     alu_result;
  logic      take;
  logic      advance;
  logic      commit_we;

  rv_decoder u_decoder (
    .i_insn      (i_insn),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_imm       (imm),
    .o_alu_op    (alu_op),
    .o_use_imm   (use_imm),
    .o_reg_we    (reg_we),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_stop      (stop)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_we       (commit_we),
    .i_rd       (rd),
    .i_rd_data  (alu_result),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // second operand, immediate or rs2
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .i_op     (alu_op),
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .i_pc     (o_pc),
    .o_result (alu_result),
    .o_take   (take)
  );

  rv_pc_counter #(
    .RESET_PC (RESET_PC)
  ) u_pc_counter (
    .clk         (clk),
    .rst         (rst),
    .i_advance   (advance),
    .i_is_branch (is_branch),
    .i_take      (take),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_imm       (imm),
    .i_rs1_data  (rs1_data),
    .o_pc        (o_pc)
  );

  rv_run_ctrl u_run_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_stop      (stop),
    .i_reg_we    (reg_we),
    .o_advance   (advance),
    .o_commit_we (commit_we),
    .o_halt      (o_halt)
  );

  // commit port mirrors the register write
  assign o_commit_we   = commit_we;
  assign o_commit_rd   = rd;
  assign o_commit_data = alu_result;

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
  input  word_t     i_insn,
  output reg_addr_t o_rs1,
  output reg_addr_t o_rs2,
  output reg_addr_t o_rd,
  output word_t     o_imm,
  output alu_op_e   o_alu_op,
  output logic      o_use_imm,
  output logic      o_reg_we,
  output logic      o_is_branch,
  output logic      o_is_jal,
  output logic      o_is_jalr,
  output logic      o_stop
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  // sign-extended immediates
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'd0};

  // shared by register-immediate and register-register forms
  function automatic alu_op_e base_op(input logic [2:0] f3);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    o_imm       = imm_i;
    o_alu_op    = ALU_ADD;
    o_use_imm   = 1'b0;
    o_reg_we    = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_stop      = 1'b0;
    case (opcode)
      OP_REG_IMM: begin
        o_use_imm = 1'b1;
        o_reg_we  = 1'b1;
        o_alu_op  = base_op(funct3);
        // shamt sits in imm[4:0], upper bits pick the shift kind
        if (funct3 == F3_SLL && funct7 != F7_BASE) begin
          o_stop = 1'b1;
        end else if (funct3 == F3_SR) begin
          if (funct7 == F7_ALT) begin
            o_alu_op = ALU_SRA;
          end else if (funct7 != F7_BASE) begin
            o_stop = 1'b1;
          end
        end
      end
      OP_REG_REG: begin
        o_reg_we = 1'b1;
        if (funct7 == F7_BASE) begin
          o_alu_op = base_op(funct3);
        end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
          o_alu_op = ALU_SUB;
        end else if (funct7 == F7_ALT && funct3 == F3_SR) begin
          o_alu_op = ALU_SRA;
        end else begin
          o_stop = 1'b1;
        end
      end
      OP_LUI: begin
        o_imm     = imm_u;
        o_use_imm = 1'b1;
        o_alu_op  = ALU_PASS_B;
        o_reg_we  = 1'b1;
      end
      OP_BRANCH: begin
        o_imm       = imm_b;
        o_is_branch = 1'b1;
        case (funct3)
          F3_BEQ:  o_alu_op = ALU_EQ;
          F3_BNE:  o_alu_op = ALU_NE;
          F3_BLT:  o_alu_op = ALU_LT;
          F3_BGE:  o_alu_op = ALU_GE;
          F3_BLTU: o_alu_op = ALU_LTU;
          F3_BGEU: o_alu_op = ALU_GEU;
          default: o_stop = 1'b1;
        endcase
      end
      OP_JAL: begin
        o_imm    = imm_j;
        o_is_jal = 1'b1;
        o_alu_op = ALU_LINK;
        o_reg_we = 1'b1;
      end
      OP_JALR: begin
        o_is_jalr = 1'b1;
        o_alu_op  = ALU_LINK;
        o_reg_we  = 1'b1;
        o_stop    = (funct3 != 3'b000);
      end
      // ecall, and every other system encoding is unsupported
      OP_SYSTEM: o_stop = 1'b1;
      default:   o_stop = 1'b1;
    endcase
    // a stopping instruction never writes
    if (o_stop) begin
      o_reg_we = 1'b0;
    end
  end

endmodule

// ==== hw/rv_pc_counter.sv ====
`timescale 1ns/1ns

module rv_pc_counter import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_advance,
  input  logic  i_is_branch,
  input  logic  i_take,
  input  logic  i_is_jal,
  input  logic  i_is_jalr,
  input  word_t i_imm,
  input  word_t i_rs1_data,
  output word_t o_pc
);

  word_t pc;
  word_t pc_next;
  word_t jalr_target;

  // jalr drops bit 0 of the sum
  assign jalr_target = (i_rs1_data + i_imm) & ~word_t'(1);

  always_comb begin
    if (i_is_jalr) begin
      pc_next = jalr_target;
    end else if (i_is_jal || (i_is_branch && i_take)) begin
      pc_next = pc + i_imm;
    end else begin
      pc_next = pc + INSN_BYTES;
    end
  end

  // holds while halted
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (i_advance) begin
      pc <= pc_next;
    end
  end

  assign o_pc = pc;

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", o_pc);

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

  // register and address values
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] reg_addr_t;

  // shift amount, low bits of rs2 or the immediate
  typedef logic [4:0] shamt_t;

  // pc step between instructions
  localparam word_t INSN_BYTES = 32'd4;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // lui passes the immediate through
    ALU_PASS_B,
    // jal and jalr write pc + 4
    ALU_LINK,
    // branch compares, these drive only the take flag
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // major opcodes
  localparam logic [6:0] OP_REG_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG_REG = 7'b0110011;
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_JAL     = 7'b1101111;
  localparam logic [6:0] OP_JALR    = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

  // funct7, alt marks sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // funct3 for alu instructions
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  i_rs1,
  input  logic [4:0]  i_rs2,
  input  logic        i_we,
  input  logic [4:0]  i_rd,
  input  logic [31:0] i_rd_data,
  output logic [31:0] o_rs1_data,
  output logic [31:0] o_rs2_data
);

  localparam int NUM_REGS = 32;

  logic [31:0] regs [NUM_REGS];

  // combinational read ports
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (i_we && i_rd != 5'd0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // x0 reads zero on both ports, also right after a write aimed at it
  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    ((i_rs1 == 5'd0) -> (o_rs1_data == 32'd0)) &&
    ((i_rs2 == 5'd0) -> (o_rs2_data == 32'd0))
  ) else $error("x0 read back nonzero");

endmodule

// ==== hw/rv_run_ctrl.sv ====
`timescale 1ns/1ns

module rv_run_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic i_stop,
  input  logic i_reg_we,
  output logic o_advance,
  output logic o_commit_we,
  output logic o_halt
);

  typedef enum logic {
    ST_RUN,
    ST_HALTED
  } state_e;

  state_e state;

  // halted is left only through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_RUN;
    end else if (state == ST_RUN && i_stop) begin
      state <= ST_HALTED;
    end
  end

  // pc freezes on the stopping instruction
  assign o_advance   = (state == ST_RUN) && !i_stop;
  assign o_commit_we = (state == ST_RUN) && i_reg_we;
  assign o_halt      = (state == ST_HALTED);

  // halt holds with no writes and no pc movement
  a_halt_quiet: assert property (
    @(posedge clk) disable iff (rst) o_halt |=> (o_halt && !o_commit_we && !o_advance)
  ) else $error("activity after halt");

endmodule

// ==== project.f ====
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_pc_counter.sv
hw/rv_run_ctrl.sv
hw/rv_core.sv
bench/tb_rv_core.sv
